// File: fp_pkg.sv
// Package for the FP add pipeline
// Lane and thread counts, IEEE 754 and pipeline types, register addresses
package fp_pkg;
	// Machine dimensions
	localparam int VECTOR_LANES = 4;
	localparam int THREADS = 4;

	// Alignment shifts beyond this leave nothing of the smaller operand
	localparam logic [4:0] MAX_SHIFT = 5'd24;

	// Register block word addresses
	localparam logic [1:0] CSR_CONTROL = 2'd0;
	localparam logic [1:0] CSR_COMPLETED = 2'd1;
	localparam logic [1:0] CSR_SQUASHED = 2'd2;

	typedef logic [$clog2(THREADS)-1:0] thread_idx_t;
	typedef logic [3:0] subcycle_t;
	typedef logic [VECTOR_LANES-1:0] lane_mask_t;

	// Single precision fields
	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent;
		logic [22:0] significand;
	} ieee754_binary32;

	typedef ieee754_binary32 [VECTOR_LANES-1:0] vector_t;

	typedef enum logic [1:0]
	{
		OP_FADD,
		OP_FSUB,
		OP_OTHER
	} alu_op_t;

	// Which execution pipeline owns the instruction
	typedef enum logic [1:0]
	{
		PIPE_SCALAR_ARITH,
		PIPE_MCYCLE_ARITH,
		PIPE_MEM
	} pipeline_sel_t;

	typedef struct packed
	{
		alu_op_t alu_op;
		pipeline_sel_t pipeline_sel;
		logic [4:0] dest_reg;
	} decoded_instruction_t;

	// From operand fetch
	typedef struct packed
	{
		logic valid;
		decoded_instruction_t instruction;
		lane_mask_t mask;
		thread_idx_t thread_idx;
		subcycle_t subcycle;
	} issue_t;

	// Travels with the data down the stages
	typedef struct packed
	{
		logic valid;
		decoded_instruction_t instruction;
		lane_mask_t mask;
		thread_idx_t thread_idx;
		subcycle_t subcycle;
	} pipe_ctl_t;

	// Stage one to stage two, larger magnitude in significand1
	typedef struct packed
	{
		logic [23:0] significand1;
		logic [23:0] significand2;
		logic [4:0] shift_amount;
		logic [7:0] exponent;
		logic logical_subtract;
		logic result_sign;
	} align_lane_t;

	// Stage two to stage three, sum bit 24 is the carry
	typedef struct packed
	{
		logic [24:0] sum;
		logic [7:0] exponent;
		logic sign;
	} sum_lane_t;
endpackage

// File: fp_add_align.sv
`timescale 1ns/1ps
// FP add stage one
// Magnitude compare and swap, saturated shift amount, rollback squash
module fp_add_align (
	input logic clk,
	input logic reset,
	input logic rollback_en,
	input fp_pkg::thread_idx_t rollback_thread_idx,
	input fp_pkg::issue_t issue,
	input fp_pkg::vector_t operand1,
	input fp_pkg::vector_t operand2,
	output fp_pkg::pipe_ctl_t ctl,
	output fp_pkg::align_lane_t [fp_pkg::VECTOR_LANES-1:0] lanes,
	output logic squash
);
	logic is_subtract;
	logic is_mcycle;
	logic thread_rolled_back;

	// Order one lane so the larger magnitude comes first
	function automatic fp_pkg::align_lane_t align_one(
		input fp_pkg::ieee754_binary32 fop1,
		input fp_pkg::ieee754_binary32 fop2,
		input logic subtract
	);
		fp_pkg::align_lane_t lane;
		logic [7:0] exp1;
		logic [7:0] exp2;
		logic [23:0] sig1;
		logic [23:0] sig2;
		logic [7:0] exp_diff;

		// Subnormals lack the hidden bit but scale like exponent 1
		exp1 = (fop1.exponent == 8'd0) ? 8'd1 : fop1.exponent;
		exp2 = (fop2.exponent == 8'd0) ? 8'd1 : fop2.exponent;
		sig1 = {fop1.exponent != 8'd0, fop1.significand};
		sig2 = {fop2.exponent != 8'd0, fop2.significand};

		if (exp1 > exp2 || (exp1 == exp2 && sig1 > sig2))
		begin
			// Already in order
			lane.significand1 = sig1;
			lane.significand2 = sig2;
			lane.exponent = exp1;
			exp_diff = exp1 - exp2;
			lane.result_sign = fop1.sign;
		end
		else
		begin
			// Swapped, operand2 sign flips on subtract
			lane.significand1 = sig2;
			lane.significand2 = sig1;
			lane.exponent = exp2;
			exp_diff = exp2 - exp1;
			lane.result_sign = fop2.sign ^ subtract;
		end

		// Saturate so stage two shifts everything out
		lane.shift_amount = (exp_diff > {3'b000, fp_pkg::MAX_SHIFT})
			? fp_pkg::MAX_SHIFT : exp_diff[4:0];
		lane.logical_subtract = fop1.sign ^ fop2.sign ^ subtract;
		return lane;
	endfunction

	assign is_subtract = issue.instruction.alu_op == fp_pkg::OP_FSUB;
	assign is_mcycle = issue.instruction.pipeline_sel == fp_pkg::PIPE_MCYCLE_ARITH;
	assign thread_rolled_back = rollback_en && rollback_thread_idx == issue.thread_idx;

	// Lane data carries no reset
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < fp_pkg::VECTOR_LANES; i++)
		begin
			lanes[i] <= align_one(operand1[i], operand2[i], is_subtract);
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ctl <= '0;
			squash <= 1'b0;
		end
		else
		begin
			// Only FADD/FSUB on the multicycle pipe go through
			ctl.valid <= issue.valid && is_mcycle && !thread_rolled_back
				&& issue.instruction.alu_op != fp_pkg::OP_OTHER;
			ctl.instruction <= issue.instruction;
			ctl.mask <= issue.mask;
			ctl.thread_idx <= issue.thread_idx;
			ctl.subcycle <= issue.subcycle;
			// Dropped by rollback
			squash <= issue.valid && is_mcycle && thread_rolled_back;
		end
	end

	genvar lane_idx;
	generate
		for (lane_idx = 0; lane_idx < fp_pkg::VECTOR_LANES; lane_idx++)
		begin : shift_check
			// Saturation keeps stage two shifter in range
			shift_saturated: assert property (@(posedge clk) disable iff (reset)
				ctl.valid |-> lanes[lane_idx].shift_amount <= fp_pkg::MAX_SHIFT);
		end
	endgenerate
endmodule

// File: fp_add_sum.sv
`timescale 1ns/1ps
// FP add stage two
// Aligns the smaller significand and adds or subtracts per lane
module fp_add_sum (
	input logic clk,
	input logic reset,
	input fp_pkg::pipe_ctl_t ctl_in,
	input fp_pkg::align_lane_t [fp_pkg::VECTOR_LANES-1:0] lanes_in,
	output fp_pkg::pipe_ctl_t ctl,
	output fp_pkg::sum_lane_t [fp_pkg::VECTOR_LANES-1:0] lanes
);
	// One lane of align and add
	function automatic fp_pkg::sum_lane_t sum_one(input fp_pkg::align_lane_t lane);
		fp_pkg::sum_lane_t result;
		logic [23:0] aligned;

		// Bits shifted out are dropped, truncation
		aligned = lane.significand2 >> lane.shift_amount;

		// Operands ordered so difference is never negative
		if (lane.logical_subtract)
		begin
			result.sum = {1'b0, lane.significand1} - {1'b0, aligned};
		end
		else
		begin
			result.sum = {1'b0, lane.significand1} + {1'b0, aligned};
		end

		result.exponent = lane.exponent;
		result.sign = lane.result_sign;
		return result;
	endfunction

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < fp_pkg::VECTOR_LANES; i++)
		begin
			lanes[i] <= sum_one(lanes_in[i]);
		end
	end

	// Control passes along unchanged
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ctl <= '0;
		end
		else
		begin
			ctl <= ctl_in;
		end
	end
endmodule

// File: fp_add_normalize.sv
`timescale 1ns/1ps
// FP add stage three
// Leading one normalize, flush-to-zero, mask and pack
module fp_add_normalize (
	input logic clk,
	input logic reset,
	input fp_pkg::pipe_ctl_t ctl_in,
	input fp_pkg::sum_lane_t [fp_pkg::VECTOR_LANES-1:0] lanes_in,
	input logic ftz_en,
	output fp_pkg::pipe_ctl_t ctl,
	output fp_pkg::vector_t result
);
	// Normalize and pack one lane
	function automatic fp_pkg::ieee754_binary32 normalize_one(
		input fp_pkg::sum_lane_t lane,
		input logic lane_enabled,
		input logic flush
	);
		fp_pkg::ieee754_binary32 packed_val;
		logic [4:0] lead_zeros;
		logic [4:0] norm_shift;
		logic [23:0] shifted;

		packed_val = '0;
		lead_zeros = 5'd0;
		norm_shift = 5'd0;

		// Scan up from bit 0 so the highest set bit wins
		for (int b = 0; b < 24; b++)
		begin
			if (lane.sum[b])
			begin
				lead_zeros = 5'(23 - b);
			end
		end

		if (lane.sum[24])
		begin
			// Carry out, one step right
			packed_val.sign = lane.sign;
			packed_val.exponent = lane.exponent + 8'd1;
			packed_val.significand = lane.sum[23:1];
		end
		else if (lane.sum[23:0] != 24'd0)
		begin
			// Exponent 1 is the floor, below that the result stays subnormal
			if ({3'b000, lead_zeros} < lane.exponent)
			begin
				norm_shift = lead_zeros;
				packed_val.exponent = lane.exponent - {3'b000, lead_zeros};
			end
			else
			begin
				norm_shift = 5'(lane.exponent - 8'd1);
				packed_val.exponent = 8'd0;
			end
			shifted = lane.sum[23:0] << norm_shift;
			packed_val.sign = lane.sign;
			packed_val.significand = shifted[22:0];
		end
		// zero sum falls through as +0

		// Subnormal to signed zero
		if (flush && packed_val.exponent == 8'd0)
		begin
			packed_val.significand = 23'd0;
		end

		if (!lane_enabled)
		begin
			packed_val = '0;
		end
		return packed_val;
	endfunction

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < fp_pkg::VECTOR_LANES; i++)
		begin
			result[i] <= normalize_one(lanes_in[i], ctl_in.mask[i], ftz_en);
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ctl <= '0;
		end
		else
		begin
			ctl <= ctl_in;
		end
	end

	// Stage one filters non add/sub ops
	no_other_op: assert property (@(posedge clk) disable iff (reset)
		ctl.valid |-> ctl.instruction.alu_op != fp_pkg::OP_OTHER);
endmodule

// File: fp_csr.sv
`timescale 1ns/1ps
// Wishbone classic register block
// Flush-to-zero control, completed and squashed counters
module fp_csr (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	input logic complete,
	input logic squash,
	output logic ftz_en
);
	logic request;
	logic write_strobe;
	logic [31:0] completed_count;
	logic [31:0] squashed_count;

	// Write clears, otherwise count up and hold at all ones
	function automatic logic [31:0] next_count(
		input logic [31:0] count,
		input logic clear,
		input logic incr
	);
		if (clear)
		begin
			return 32'd0;
		end
		else if (incr && count != '1)
		begin
			return count + 32'd1;
		end
		return count;
	endfunction

	assign request = wb_cyc && wb_stb;
	// Writes land on the acknowledge cycle
	assign write_strobe = wb_ack && request && wb_we;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			ftz_en <= 1'b0;
			completed_count <= 32'd0;
			squashed_count <= 32'd0;
		end
		else
		begin
			// One wait state then a single cycle ack
			wb_ack <= request && !wb_ack;
			if (write_strobe && wb_adr == fp_pkg::CSR_CONTROL)
			begin
				ftz_en <= wb_dat_w[0];
			end
			completed_count <= next_count(completed_count,
				write_strobe && wb_adr == fp_pkg::CSR_COMPLETED, complete);
			squashed_count <= next_count(squashed_count,
				write_strobe && wb_adr == fp_pkg::CSR_SQUASHED, squash);
		end
	end

	// Read data only during ack
	always_comb
	begin
		wb_dat_r = 32'd0;
		if (wb_ack)
		begin
			case (wb_adr)
				fp_pkg::CSR_CONTROL: wb_dat_r = {31'd0, ftz_en};
				fp_pkg::CSR_COMPLETED: wb_dat_r = completed_count;
				fp_pkg::CSR_SQUASHED: wb_dat_r = squashed_count;
				default: wb_dat_r = 32'd0;
			endcase
		end
	end

	// Held request must not stretch the ack
	single_ack: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack);
endmodule

// File: fp_add_unit.sv
`timescale 1ns/1ps
// Top of the FP add unit
// Three pipeline stages plus the Wishbone register block
module fp_add_unit (
	input logic clk,
	input logic reset,
	input fp_pkg::issue_t issue,
	input fp_pkg::vector_t operand1,
	input fp_pkg::vector_t operand2,
	input logic rollback_en,
	input fp_pkg::thread_idx_t rollback_thread_idx,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output fp_pkg::pipe_ctl_t result_ctl,
	output fp_pkg::vector_t result
);
	fp_pkg::pipe_ctl_t align_ctl;
	fp_pkg::align_lane_t [fp_pkg::VECTOR_LANES-1:0] align_lanes;
	fp_pkg::pipe_ctl_t sum_ctl;
	fp_pkg::sum_lane_t [fp_pkg::VECTOR_LANES-1:0] sum_lanes;
	logic squash;
	logic ftz_en;

	fp_add_align u_align (
		.clk(clk),
		.reset(reset),
		.rollback_en(rollback_en),
		.rollback_thread_idx(rollback_thread_idx),
		.issue(issue),
		.operand1(operand1),
		.operand2(operand2),
		.ctl(align_ctl),
		.lanes(align_lanes),
		.squash(squash)
	);

	fp_add_sum u_sum (
		.clk(clk),
		.reset(reset),
		.ctl_in(align_ctl),
		.lanes_in(align_lanes),
		.ctl(sum_ctl),
		.lanes(sum_lanes)
	);

	fp_add_normalize u_normalize (
		.clk(clk),
		.reset(reset),
		.ctl_in(sum_ctl),
		.lanes_in(sum_lanes),
		.ftz_en(ftz_en),
		.ctl(result_ctl),
		.result(result)
	);

	// Completion counted from the final valid
	fp_csr u_csr (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.complete(result_ctl.valid),
		.squash(squash),
		.ftz_en(ftz_en)
	);
endmodule

// File: tb_fp_add_unit.sv
`timescale 1ns/1ps
// Testbench for the FP add unit
// Table of vector add/sub operations, latency and order checks, Wishbone register checks
module tb_fp_add_unit;
	localparam int ACK_LIMIT = 16;
	localparam int DRAIN_LIMIT = 32;
	localparam int FILLER_COUNT = 4;

	// Lane 3 first, lane 0 last
	localparam fp_pkg::vector_t add_op1 = {32'h53800000, 32'h40000000, 32'hC0800000, 32'h3FC00000};
	localparam fp_pkg::vector_t add_op2 = {32'h3F800000, 32'h40000000, 32'h3F800000, 32'h40100000};
	localparam fp_pkg::vector_t add_sum = {32'h53800000, 32'h40800000, 32'hC0400000, 32'h40700000};
	localparam fp_pkg::vector_t add_masked = {32'h00000000, 32'h40800000, 32'h00000000, 32'h40700000};
	localparam fp_pkg::vector_t sub_op1 = {32'h3F800000, 32'h3F800001, 32'h40A00000, 32'h3F800000};
	localparam fp_pkg::vector_t sub_op2 = {32'h53800000, 32'h3F800000, 32'h40A00000, 32'h40400000};
	localparam fp_pkg::vector_t sub_diff = {32'hD3800000, 32'h34000000, 32'h00000000, 32'hC0000000};
	// Differences that fall below the smallest normal
	localparam fp_pkg::vector_t tiny_op1 = {32'h40400000, 32'h00C00000, 32'h80800001, 32'h00800001};
	localparam fp_pkg::vector_t tiny_op2 = {32'h3F800000, 32'h00800000, 32'h80800000, 32'h00800000};
	localparam fp_pkg::vector_t tiny_kept = {32'h40000000, 32'h00400000, 32'h80000001, 32'h00000001};
	localparam fp_pkg::vector_t tiny_flushed = {32'h40000000, 32'h00000000, 32'h80000000, 32'h00000000};

	typedef struct {
		fp_pkg::alu_op_t op;
		fp_pkg::pipeline_sel_t sel;
		fp_pkg::lane_mask_t mask;
		fp_pkg::thread_idx_t thread;
		logic rb_en;
		fp_pkg::thread_idx_t rb_thread;
		logic ftz;
		fp_pkg::vector_t op1;
		fp_pkg::vector_t op2;
		fp_pkg::vector_t expected;
		logic has_result;
	} entry_t;

	// One result still owed by the DUT
	typedef struct {
		fp_pkg::vector_t result;
		fp_pkg::pipe_ctl_t ctl;
		int due;
		int index;
	} pending_t;

	logic clk;
	logic reset;
	fp_pkg::issue_t issue;
	fp_pkg::vector_t operand1;
	fp_pkg::vector_t operand2;
	logic rollback_en;
	fp_pkg::thread_idx_t rollback_thread_idx;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	fp_pkg::pipe_ctl_t result_ctl;
	fp_pkg::vector_t result;

	entry_t tbl[$];
	pending_t pending[$];
	int cycle_count = 0;
	int checks = 0;
	int errors = 0;
	logic [15:0] lfsr_state = 16'd29;

	fp_add_unit DUT (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.operand1(operand1),
		.operand2(operand2),
		.rollback_en(rollback_en),
		.rollback_thread_idx(rollback_thread_idx),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.result_ctl(result_ctl),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	// Galois LFSR, one step per bit
	function automatic logic next_random_bit();
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		return lfsr_state[0];
	endfunction

	task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
		input string msg);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s got %h expected %h", $time, msg, actual, expected);
		end
	endtask

	task automatic add_entry(input fp_pkg::alu_op_t op, input fp_pkg::pipeline_sel_t sel,
		input fp_pkg::lane_mask_t mask, input fp_pkg::thread_idx_t thread,
		input logic rb_en, input fp_pkg::thread_idx_t rb_thread, input logic ftz,
		input fp_pkg::vector_t op1, input fp_pkg::vector_t op2,
		input fp_pkg::vector_t expected, input logic has_result);
		entry_t e;
		e.op = op;
		e.sel = sel;
		e.mask = mask;
		e.thread = thread;
		e.rb_en = rb_en;
		e.rb_thread = rb_thread;
		e.ftz = ftz;
		e.op1 = op1;
		e.op2 = op2;
		e.expected = expected;
		e.has_result = has_result;
		tbl.push_back(e);
	endtask

	// Random thread and mask, but never an add on the multicycle pipe
	task automatic add_fillers(input int count);
		fp_pkg::thread_idx_t thread;
		fp_pkg::lane_mask_t mask;
		for (int k = 0; k < count; k++)
		begin
			for (int b = 0; b < 2; b++)
			begin
				thread[b] = next_random_bit();
			end
			for (int b = 0; b < fp_pkg::VECTOR_LANES; b++)
			begin
				mask[b] = next_random_bit();
			end
			if (next_random_bit())
			begin
				add_entry(fp_pkg::OP_FADD, fp_pkg::PIPE_MEM, mask, thread, 1'b0, 2'd0, 1'b0,
					add_op1, add_op2, '0, 1'b0);
			end
			else
			begin
				add_entry(fp_pkg::OP_OTHER, fp_pkg::PIPE_MCYCLE_ARITH, mask, thread, 1'b0,
					2'd0, 1'b0, add_op1, add_op2, '0, 1'b0);
			end
		end
	endtask

	// Drive one table entry, called right after a rising edge
	task automatic apply_entry(input int idx);
		fp_pkg::issue_t next_issue;
		pending_t item;
		next_issue.valid = 1'b1;
		next_issue.instruction.alu_op = tbl[idx].op;
		next_issue.instruction.pipeline_sel = tbl[idx].sel;
		next_issue.instruction.dest_reg = 5'(idx + 1);
		next_issue.mask = tbl[idx].mask;
		next_issue.thread_idx = tbl[idx].thread;
		next_issue.subcycle = 4'(idx);
		issue <= next_issue;
		operand1 <= tbl[idx].op1;
		operand2 <= tbl[idx].op2;
		rollback_en <= tbl[idx].rb_en;
		rollback_thread_idx <= tbl[idx].rb_thread;
		if (tbl[idx].has_result)
		begin
			// Control fields come back untouched
			item.result = tbl[idx].expected;
			item.ctl.valid = 1'b1;
			item.ctl.instruction = next_issue.instruction;
			item.ctl.mask = next_issue.mask;
			item.ctl.thread_idx = next_issue.thread_idx;
			item.ctl.subcycle = next_issue.subcycle;
			// Issue visible next cycle, result three edges on
			item.due = cycle_count + 4;
			item.index = idx;
			pending.push_back(item);
		end
	endtask

	// One Wishbone classic transfer
	task automatic wb_transfer(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int waited;
		logic got_ack;
		waited = 0;
		got_ack = 1'b0;
		rdata = 32'd0;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		while (!got_ack && waited < ACK_LIMIT)
		begin
			@(negedge clk);
			waited++;
			if (wb_ack)
			begin
				got_ack = 1'b1;
				rdata = wb_dat_r;
			end
		end
		// Write lands on this edge
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		if (!got_ack)
		begin
			errors++;
			$display("Timeout: no wb_ack for access to address %0d", adr);
		end
		else
		begin
			// Ack one clock after the request is seen
			check_equal(128'(waited), 128'd2, "wb_ack latency");
		end
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (pending.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (pending.size() != 0)
		begin
			errors++;
			$display("Timeout: %0d results never arrived", pending.size());
		end
	endtask

	// Outputs sampled mid cycle
	always @(negedge clk)
	begin : result_monitor
		pending_t item;
		if (!reset)
		begin
			if (result_ctl.valid)
			begin
				if (pending.size() == 0)
				begin
					errors++;
					$display("[FAIL] %0t: result valid with nothing pending", $time);
				end
				else
				begin
					item = pending.pop_front();
					check_equal(128'(cycle_count), 128'(item.due), "result latency");
					check_equal(result, item.result, "result vector");
					check_equal(128'(result_ctl), 128'(item.ctl), "result control");
				end
			end
			else if (pending.size() != 0 && cycle_count >= pending[0].due)
			begin
				item = pending.pop_front();
				errors++;
				$display("Missing result for table entry %0d at %0t", item.index, $time);
			end
		end
	end

	initial
	begin
		logic [31:0] rdata;
		logic ftz_now;
		int exp_completed;
		int exp_squashed;

		reset = 1'b1;
		issue = '0;
		operand1 = '0;
		operand2 = '0;
		rollback_en = 1'b0;
		rollback_thread_idx = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = 32'd0;
		ftz_now = 1'b0;
		exp_completed = 0;
		exp_squashed = 0;

		// Basic add/sub, swap, sign and saturated shift
		add_entry(fp_pkg::OP_FADD, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd0, 1'b0, 2'd0, 1'b0,
			add_op1, add_op2, add_sum, 1'b1);
		add_entry(fp_pkg::OP_FSUB, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd3, 1'b0, 2'd0, 1'b0,
			sub_op1, sub_op2, sub_diff, 1'b1);
		add_entry(fp_pkg::OP_FADD, fp_pkg::PIPE_MCYCLE_ARITH, 4'b0101, 2'd1, 1'b0, 2'd0, 1'b0,
			add_op1, add_op2, add_masked, 1'b1);
		// Own thread rolled back
		add_entry(fp_pkg::OP_FADD, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd2, 1'b1, 2'd2, 1'b0,
			add_op1, add_op2, '0, 1'b0);
		// Other thread rolled back, result still due
		add_entry(fp_pkg::OP_FADD, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd1, 1'b1, 2'd3, 1'b0,
			add_op1, add_op2, add_sum, 1'b1);
		add_entry(fp_pkg::OP_OTHER, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd0, 1'b0, 2'd0, 1'b0,
			add_op1, add_op2, '0, 1'b0);
		add_entry(fp_pkg::OP_FADD, fp_pkg::PIPE_SCALAR_ARITH, 4'b1111, 2'd3, 1'b0, 2'd0, 1'b0,
			add_op1, add_op2, '0, 1'b0);
		add_entry(fp_pkg::OP_FSUB, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd0, 1'b1, 2'd0, 1'b0,
			sub_op1, sub_op2, '0, 1'b0);
		add_entry(fp_pkg::OP_FSUB, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd2, 1'b0, 2'd0, 1'b0,
			tiny_op1, tiny_op2, tiny_kept, 1'b1);
		add_fillers(FILLER_COUNT);
		// Same operands with flush-to-zero on
		add_entry(fp_pkg::OP_FSUB, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd1, 1'b0, 2'd0, 1'b1,
			tiny_op1, tiny_op2, tiny_flushed, 1'b1);
		// Flush-to-zero off again, subnormals kept
		add_entry(fp_pkg::OP_FSUB, fp_pkg::PIPE_MCYCLE_ARITH, 4'b1111, 2'd3, 1'b0, 2'd0, 1'b0,
			tiny_op1, tiny_op2, tiny_kept, 1'b1);

		repeat (2) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < tbl.size(); i++)
		begin
			if (tbl[i].ftz != ftz_now)
			begin
				// Empty pipe before flush-to-zero changes
				@(posedge clk);
				issue.valid <= 1'b0;
				rollback_en <= 1'b0;
				drain_results();
				wb_transfer(1'b1, fp_pkg::CSR_CONTROL, {31'd0, tbl[i].ftz}, rdata);
				wb_transfer(1'b0, fp_pkg::CSR_CONTROL, 32'd0, rdata);
				check_equal(128'(rdata), 128'(tbl[i].ftz), "ftz readback");
				ftz_now = tbl[i].ftz;
			end
			@(posedge clk);
			apply_entry(i);
		end

		@(posedge clk);
		issue.valid <= 1'b0;
		rollback_en <= 1'b0;
		drain_results();
		// Late stray results would show up within three edges
		repeat (4) @(posedge clk);

		// Counts expected from the table
		foreach (tbl[i])
		begin
			if (tbl[i].has_result)
			begin
				exp_completed++;
			end
			if (tbl[i].rb_en && tbl[i].rb_thread == tbl[i].thread
				&& tbl[i].sel == fp_pkg::PIPE_MCYCLE_ARITH)
			begin
				exp_squashed++;
			end
		end

		wb_transfer(1'b0, fp_pkg::CSR_COMPLETED, 32'd0, rdata);
		check_equal(128'(rdata), 128'(exp_completed), "completed count");
		wb_transfer(1'b0, fp_pkg::CSR_SQUASHED, 32'd0, rdata);
		check_equal(128'(rdata), 128'(exp_squashed), "squashed count");
		// Writes clear the counters
		wb_transfer(1'b1, fp_pkg::CSR_COMPLETED, 32'hFFFFFFFF, rdata);
		wb_transfer(1'b0, fp_pkg::CSR_COMPLETED, 32'd0, rdata);
		check_equal(128'(rdata), 128'd0, "completed after clear");
		wb_transfer(1'b1, fp_pkg::CSR_SQUASHED, 32'hFFFFFFFF, rdata);
		wb_transfer(1'b0, fp_pkg::CSR_SQUASHED, 32'd0, rdata);
		check_equal(128'(rdata), 128'd0, "squashed after clear");
		wb_transfer(1'b0, 2'd3, 32'd0, rdata);
		check_equal(128'(rdata), 128'd0, "unmapped address");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end
endmodule

// File: compile.f
fp_pkg.sv
fp_add_align.sv
fp_add_sum.sv
fp_add_normalize.sv
fp_csr.sv
fp_add_unit.sv
tb_fp_add_unit.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_fp_add_unit -o sim_fp_add \
	&& ./obj_dir/sim_fp_add > sim.log 2>&1 \
	&& cat sim.log \
	&& ! grep -q -F '** FAIL **' sim.log \
	&& echo "simulation passed" \
	|| { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
